/* emu_ctrl_vectors.txt */
// Columns in hex: op addr data strb expected
// op 1 write (expected bresp), 2 read (expected rdata), 3 trigger (data drives dut_trig,
// expected {dut_reset, dut_halt}), 4 descriptor (data length, strb direction, expected
// address), 5 status (data is the error), 6 poll (read until rdata & data equals expected)
2 000 00000000 0 3
2 020 00000000 0 0
2 014 00000000 0 100
2 004 00000000 0 0
3 000 00000000 0 3
1 018 89abcdef f 0
2 018 00000000 0 89abcdef
1 01c 00000012 f 0
2 01c 00000000 0 12
1 018 11111111 3 2
2 018 00000000 0 89abcdef
1 008 00000100 f 0
1 00c 00000000 f 0
1 008 ffffffff 7 2
2 008 00000000 0 100
2 00c 00000000 0 0
1 010 00000005 f 0
1 000 00000000 f 0
6 000 00000001 0 1
2 008 00000000 0 105
2 00c 00000000 0 0
2 010 00000000 0 0
1 010 00000000 f 0
1 000 00000000 f 0
3 000 00000001 0 1
2 000 00000000 0 1
1 024 00000003 f 0
4 000 00000100 1 0000001289abcdef
2 020 00000000 0 1
1 024 00000001 f 0
2 024 00000000 0 2
2 020 00000000 0 1
5 000 00000005 0 0
2 020 00000000 0 50
1 024 00000001 f 0
4 000 00000100 0 0000001289abcdef
2 020 00000000 0 51

/* flist.f */
+incdir+.
emu_pkg.sv
csr_if.sv
emu_csr_bus.sv
emu_run_ctrl.sv
emu_ckpt_dma_ctrl.sv
emu_ctrl_top.sv
tb_emu_ctrl.sv

/* tb_emu_ctrl.sv */
`timescale 1ns/100ps
`include "emu_config.svh"

module tb_emu_ctrl;

    localparam int MAX_VECTORS       = 64;
    localparam int FIELDS            = 5;
    localparam int CYCLES_PER_VECTOR = 200;
    localparam int RESET_CYCLES      = 5;

    logic                      clk;
    logic                      rst;
    logic                      s_awvalid;
    logic                      s_awready;
    logic [`EMU_ADDR_W-1:0]    s_awaddr;
    logic                      s_wvalid;
    logic                      s_wready;
    logic [`EMU_DATA_W-1:0]    s_wdata;
    logic [`EMU_STRB_W-1:0]    s_wstrb;
    logic                      s_bvalid;
    logic                      s_bready;
    logic [1:0]                s_bresp;
    logic                      s_arvalid;
    logic                      s_arready;
    logic [`EMU_ADDR_W-1:0]    s_araddr;
    logic                      s_rvalid;
    logic                      s_rready;
    logic [`EMU_DATA_W-1:0]    s_rdata;
    logic [1:0]                s_rresp;
    logic                      dut_halt;
    logic                      dut_reset;
    logic                      dut_trig;
    logic                      desc_valid;
    logic [`EMU_WIDE_W-1:0]    desc_addr;
    logic [`EMU_DMA_LEN_W-1:0] desc_len;
    logic                      desc_dir;
    logic                      desc_ready;
    logic                      status_valid;
    logic [`EMU_DMA_ERR_W-1:0] status_error;

    // Five words per vector line: op, addr, data, strb, expected
    logic [63:0] vec_mem [0:MAX_VECTORS*FIELDS-1];
    int          num_vectors;
    int          cycle_count;
    int          cycle_limit;
    integer      seed;

    emu_ctrl_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .s_awvalid    (s_awvalid),
        .s_awready    (s_awready),
        .s_awaddr     (s_awaddr),
        .s_wvalid     (s_wvalid),
        .s_wready     (s_wready),
        .s_wdata      (s_wdata),
        .s_wstrb      (s_wstrb),
        .s_bvalid     (s_bvalid),
        .s_bready     (s_bready),
        .s_bresp      (s_bresp),
        .s_arvalid    (s_arvalid),
        .s_arready    (s_arready),
        .s_araddr     (s_araddr),
        .s_rvalid     (s_rvalid),
        .s_rready     (s_rready),
        .s_rdata      (s_rdata),
        .s_rresp      (s_rresp),
        .dut_halt     (dut_halt),
        .dut_reset    (dut_reset),
        .dut_trig     (dut_trig),
        .desc_valid   (desc_valid),
        .desc_addr    (desc_addr),
        .desc_len     (desc_len),
        .desc_dir     (desc_dir),
        .desc_ready   (desc_ready),
        .status_valid (status_valid),
        .status_error (status_error)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s actual 0x%0h expected 0x%0h", $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        logic aw_done;
        logic w_done;
        logic aw_go;
        logic w_go;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge clk);
        s_awvalid <= 1'b1;
        s_awaddr  <= addr;
        s_wvalid  <= 1'b1;
        s_wdata   <= data;
        s_wstrb   <= strb;
        // Address and data may be taken in different cycles
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            aw_go = s_awvalid && s_awready;
            w_go  = s_wvalid && s_wready;
            @(posedge clk);
            if (aw_go) begin
                s_awvalid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_go) begin
                s_wvalid <= 1'b0;
                w_done = 1'b1;
            end
        end
        s_bready <= 1'b1;
        @(negedge clk);
        while (!s_bvalid) @(negedge clk);
        resp = s_bresp;
        @(posedge clk);
        s_bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        s_arvalid <= 1'b1;
        s_araddr  <= addr;
        @(negedge clk);
        while (!s_arready) @(negedge clk);
        @(posedge clk);
        s_arvalid <= 1'b0;
        s_rready  <= 1'b1;
        @(negedge clk);
        while (!s_rvalid) @(negedge clk);
        data = s_rdata;
        check_value("s_rresp", s_rresp, 2'b00);
        @(posedge clk);
        s_rready <= 1'b0;
    endtask

    // Read until the masked value matches, the cycle limit guards the loop
    task automatic poll_read(input logic [11:0] addr, input logic [31:0] mask,
                             input logic [31:0] expected);
        logic [31:0] data;
        axil_read(addr, data);
        while ((data & mask) !== expected) axil_read(addr, data);
    endtask

    task automatic pulse_trigger(input logic trig, input logic [1:0] exp_pins);
        @(posedge clk);
        dut_trig <= trig;
        @(posedge clk);
        dut_trig <= 1'b0;
        @(negedge clk);
        check_value("{dut_reset, dut_halt}", {dut_reset, dut_halt}, exp_pins);
    endtask

    task automatic accept_descriptor(input logic [63:0] exp_addr, input logic [31:0] exp_len,
                                     input logic exp_dir);
        int delay;
        @(negedge clk);
        while (!desc_valid) @(negedge clk);
        check_value("desc_addr", desc_addr, exp_addr);
        check_value("desc_len", desc_len, exp_len);
        check_value("desc_dir", desc_dir, exp_dir);
        delay = $unsigned($random(seed)) % 8;
        repeat (delay) @(posedge clk);
        @(negedge clk);
        check_value("desc_valid", desc_valid, 1'b1);
        @(posedge clk);
        desc_ready <= 1'b1;
        @(posedge clk);
        desc_ready <= 1'b0;
        @(negedge clk);
        check_value("desc_valid", desc_valid, 1'b0);
    endtask

    task automatic pulse_status(input logic [3:0] error);
        @(posedge clk);
        status_valid <= 1'b1;
        status_error <= error;
        @(posedge clk);
        status_valid <= 1'b0;
        status_error <= '0;
    endtask

    task automatic run_vector(input int idx);
        logic [3:0]  op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [63:0] expected;
        logic [1:0]  resp;
        logic [31:0] rdata;
        op       = vec_mem[idx*FIELDS][3:0];
        addr     = vec_mem[idx*FIELDS+1][11:0];
        data     = vec_mem[idx*FIELDS+2][31:0];
        strb     = vec_mem[idx*FIELDS+3][3:0];
        expected = vec_mem[idx*FIELDS+4];
        case (op)
            4'd1: begin
                axil_write(addr, data, strb, resp);
                check_value($sformatf("s_bresp (addr 0x%03h)", addr), resp, expected);
            end
            4'd2: begin
                axil_read(addr, rdata);
                check_value($sformatf("s_rdata (addr 0x%03h)", addr), rdata, expected);
            end
            4'd3: pulse_trigger(data[0], expected[1:0]);
            4'd4: accept_descriptor(expected, data, strb[0]);
            4'd5: pulse_status(data[3:0]);
            4'd6: poll_read(addr, data, expected[31:0]);
            default: begin
                $display("Vector line %0d holds an unknown operation code %0d", idx, op);
                $display("STATUS: FAIL");
                $fatal(1, "Bad vector file");
            end
        endcase
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        s_awvalid    = 1'b0;
        s_awaddr     = '0;
        s_wvalid     = 1'b0;
        s_wdata      = '0;
        s_wstrb      = '0;
        s_bready     = 1'b0;
        s_arvalid    = 1'b0;
        s_araddr     = '0;
        s_rready     = 1'b0;
        dut_trig     = 1'b0;
        desc_ready   = 1'b0;
        status_valid = 1'b0;
        status_error = '0;
        seed         = 94;
        cycle_count  = 0;
        cycle_limit  = 0;
        num_vectors  = 0;

        // An op code of zero marks the end of the vectors
        for (int i = 0; i < MAX_VECTORS * FIELDS; i++) begin
            vec_mem[i] = '0;
        end
        $readmemh("emu_ctrl_vectors.txt", vec_mem);
        while (num_vectors < MAX_VECTORS && vec_mem[num_vectors*FIELDS] != 0) begin
            num_vectors++;
        end
        if (num_vectors == 0) begin
            $display("No vectors were read from emu_ctrl_vectors.txt");
            $display("STATUS: FAIL");
            $fatal(1, "Empty vector file");
        end
        cycle_limit = num_vectors * CYCLES_PER_VECTOR + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < num_vectors; i++) begin
            run_vector(i);
        end

        @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* emu_ctrl_top.sv */
`timescale 1ns/100ps
`include "emu_config.svh"

module emu_ctrl_top (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      s_awvalid,
    output logic                      s_awready,
    input  logic [`EMU_ADDR_W-1:0]    s_awaddr,
    input  logic                      s_wvalid,
    output logic                      s_wready,
    input  logic [`EMU_DATA_W-1:0]    s_wdata,
    input  logic [`EMU_STRB_W-1:0]    s_wstrb,
    output logic                      s_bvalid,
    input  logic                      s_bready,
    output logic [1:0]                s_bresp,
    input  logic                      s_arvalid,
    output logic                      s_arready,
    input  logic [`EMU_ADDR_W-1:0]    s_araddr,
    output logic                      s_rvalid,
    input  logic                      s_rready,
    output logic [`EMU_DATA_W-1:0]    s_rdata,
    output logic [1:0]                s_rresp,

    output logic                      dut_halt,
    output logic                      dut_reset,
    input  logic                      dut_trig,

    output logic                      desc_valid,
    output logic [`EMU_WIDE_W-1:0]    desc_addr,
    output logic [`EMU_DMA_LEN_W-1:0] desc_len,
    output logic                      desc_dir,
    input  logic                      desc_ready,
    input  logic                      status_valid,
    input  logic [`EMU_DMA_ERR_W-1:0] status_error
);

    // One register port per target block
    csr_if run_bus ();
    csr_if dma_bus ();

    emu_csr_bus i_csr_bus (
        .clk       (clk),
        .rst       (rst),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_awaddr  (s_awaddr),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_bresp   (s_bresp),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_araddr  (s_araddr),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .run_bus   (run_bus),
        .dma_bus   (dma_bus)
    );

    emu_run_ctrl i_run_ctrl (
        .clk       (clk),
        .rst       (rst),
        .bus       (run_bus),
        .dut_trig  (dut_trig),
        .dut_halt  (dut_halt),
        .dut_reset (dut_reset)
    );

    emu_ckpt_dma_ctrl i_ckpt_dma_ctrl (
        .clk          (clk),
        .rst          (rst),
        .bus          (dma_bus),
        .desc_valid   (desc_valid),
        .desc_addr    (desc_addr),
        .desc_len     (desc_len),
        .desc_dir     (desc_dir),
        .desc_ready   (desc_ready),
        .status_valid (status_valid),
        .status_error (status_error)
    );

endmodule

/* emu_ckpt_dma_ctrl.sv */
`timescale 1ns/100ps
`include "emu_config.svh"

module emu_ckpt_dma_ctrl import emu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    csr_if.target                     bus,
    output logic                      desc_valid,
    output logic [`EMU_WIDE_W-1:0]    desc_addr,
    output logic [`EMU_DMA_LEN_W-1:0] desc_len,
    output logic                      desc_dir,
    input  logic                      desc_ready,
    input  logic                      status_valid,
    input  logic [`EMU_DMA_ERR_W-1:0] status_error
);

    logic [`EMU_WIDE_W-1:0]    addr_q;
    logic                      start_q;
    logic                      running_q;
    dma_dir_e                  dir_q;
    logic [`EMU_DMA_ERR_W-1:0] err_q;
    logic                      wr_addr_lo;
    logic                      wr_addr_hi;
    logic                      wr_ctrl;
    logic [`EMU_DATA_W-1:0]    stat_word;
    logic [`EMU_DATA_W-1:0]    ctrl_word;

    assign wr_addr_lo = bus.wr_en && (bus.wr_addr == REG_DMA_ADDR_LO);
    assign wr_addr_hi = bus.wr_en && (bus.wr_addr == REG_DMA_ADDR_HI);

    // A new request is refused while a transfer is still outstanding
    assign wr_ctrl = bus.wr_en && (bus.wr_addr == REG_DMA_CTRL) && !running_q;

    always_ff @(posedge clk) begin
        if (wr_addr_lo) begin
            addr_q[`EMU_DATA_W-1:0] <= bus.wr_data;
        end
        if (wr_addr_hi) begin
            addr_q[`EMU_WIDE_W-1:`EMU_DATA_W] <= bus.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start_q   <= 1'b0;
            running_q <= 1'b0;
            dir_q     <= DIR_SAVE;
            err_q     <= '0;
        end else begin
            if (desc_valid && desc_ready) begin
                start_q <= 1'b0;
            end
            // Engine reports completion, error code stays until the next one
            if (status_valid) begin
                running_q <= 1'b0;
                err_q     <= status_error;
            end
            if (wr_ctrl) begin
                start_q   <= bus.wr_data[`EMU_DMA_START_BIT];
                running_q <= bus.wr_data[`EMU_DMA_START_BIT];
                dir_q     <= dma_dir_e'(bus.wr_data[`EMU_DMA_DIR_BIT]);
            end
        end
    end

    always_comb begin
        stat_word                                         = '0;
        stat_word[`EMU_DMA_RUN_BIT]                       = running_q;
        stat_word[`EMU_DMA_ERR_LSB +: `EMU_DMA_ERR_W]     = err_q;
        ctrl_word                                         = '0;
        ctrl_word[`EMU_DMA_START_BIT]                     = start_q;
        ctrl_word[`EMU_DMA_DIR_BIT]                       = dir_q;
    end

    always_comb begin
        bus.rd_hit = 1'b1;
        case (bus.rd_addr)
            REG_DMA_ADDR_LO: bus.rd_data = addr_q[`EMU_DATA_W-1:0];
            REG_DMA_ADDR_HI: bus.rd_data = addr_q[`EMU_WIDE_W-1:`EMU_DATA_W];
            REG_DMA_STAT:    bus.rd_data = stat_word;
            REG_DMA_CTRL:    bus.rd_data = ctrl_word;
            default: begin
                bus.rd_hit  = 1'b0;
                bus.rd_data = '0;
            end
        endcase
    end

    // Descriptor always covers the full checkpoint image
    assign desc_valid = start_q;
    assign desc_addr  = addr_q;
    assign desc_len   = `EMU_DMA_LEN_W'(`EMU_CKPT_BYTES);
    assign desc_dir   = dir_q;

endmodule

/* emu_run_ctrl.sv */
`timescale 1ns/100ps
`include "emu_config.svh"

module emu_run_ctrl import emu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    csr_if.target bus,
    input  logic  dut_trig,
    output logic  dut_halt,
    output logic  dut_reset
);

    logic                   halt_q;
    logic                   dut_reset_q;
    logic [`EMU_WIDE_W-1:0] cycle_q;
    logic [`EMU_DATA_W-1:0] step_q;
    logic [`EMU_DATA_W-1:0] step_next;
    logic                   step_done;
    logic                   trigger;
    logic                   wr_stat;
    logic                   wr_cycle_lo;
    logic                   wr_cycle_hi;
    logic                   wr_step;
    logic [`EMU_DATA_W-1:0] stat_word;

    assign wr_stat     = bus.wr_en && (bus.wr_addr == REG_STAT);
    assign wr_cycle_lo = bus.wr_en && (bus.wr_addr == REG_CYCLE_LO);
    assign wr_cycle_hi = bus.wr_en && (bus.wr_addr == REG_CYCLE_HI);
    assign wr_step     = bus.wr_en && (bus.wr_addr == REG_STEP);

    // Step budget runs down only while the DUT is running
    always_comb begin
        step_next = step_q;
        if (!halt_q && (step_q != '0)) begin
            step_next = step_q - 1'b1;
        end
    end

    assign step_done = (step_q != '0) && (step_next == '0);
    assign trigger   = step_done || dut_trig;

    always_ff @(posedge clk) begin
        if (rst) begin
            halt_q      <= `EMU_RST_HALT;
            dut_reset_q <= `EMU_RST_DUT_RESET;
        end else begin
            if (wr_stat) begin
                halt_q      <= bus.wr_data[`EMU_STAT_HALT_BIT];
                dut_reset_q <= bus.wr_data[`EMU_STAT_RESET_BIT];
            end
            // Trigger wins over the host clearing halt
            if (trigger) begin
                halt_q <= 1'b1;
            end
        end
    end

    // Cycle count is only writable once the DUT is stopped
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_q <= '0;
        end else if (!halt_q) begin
            cycle_q <= cycle_q + 1'b1;
        end else begin
            if (wr_cycle_lo) begin
                cycle_q[`EMU_DATA_W-1:0] <= bus.wr_data;
            end
            if (wr_cycle_hi) begin
                cycle_q[`EMU_WIDE_W-1:`EMU_DATA_W] <= bus.wr_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step_q <= '0;
        end else if (wr_step) begin
            step_q <= bus.wr_data;
        end else begin
            step_q <= step_next;
        end
    end

    always_comb begin
        stat_word                      = '0;
        stat_word[`EMU_STAT_HALT_BIT]  = halt_q;
        stat_word[`EMU_STAT_RESET_BIT] = dut_reset_q;
    end

    always_comb begin
        bus.rd_hit = 1'b1;
        case (bus.rd_addr)
            REG_STAT:      bus.rd_data = stat_word;
            REG_CTRL:      bus.rd_data = '0;
            REG_CYCLE_LO:  bus.rd_data = cycle_q[`EMU_DATA_W-1:0];
            REG_CYCLE_HI:  bus.rd_data = cycle_q[`EMU_WIDE_W-1:`EMU_DATA_W];
            REG_STEP:      bus.rd_data = step_q;
            REG_CKPT_SIZE: bus.rd_data = `EMU_DATA_W'(`EMU_CKPT_BYTES);
            default: begin
                bus.rd_hit  = 1'b0;
                bus.rd_data = '0;
            end
        endcase
    end

    assign dut_halt  = halt_q;
    assign dut_reset = dut_reset_q;

endmodule

/* emu_csr_bus.sv */
`timescale 1ns/100ps
`include "emu_config.svh"

module emu_csr_bus import emu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   s_awvalid,
    output logic                   s_awready,
    input  logic [`EMU_ADDR_W-1:0] s_awaddr,
    input  logic                   s_wvalid,
    output logic                   s_wready,
    input  logic [`EMU_DATA_W-1:0] s_wdata,
    input  logic [`EMU_STRB_W-1:0] s_wstrb,
    output logic                   s_bvalid,
    input  logic                   s_bready,
    output axil_resp_e             s_bresp,

    input  logic                   s_arvalid,
    output logic                   s_arready,
    input  logic [`EMU_ADDR_W-1:0] s_araddr,
    output logic                   s_rvalid,
    input  logic                   s_rready,
    output logic [`EMU_DATA_W-1:0] s_rdata,
    output axil_resp_e             s_rresp,

    csr_if.host                    run_bus,
    csr_if.host                    dma_bus
);

    emu_reg_e               aw_addr_q;
    logic                   aw_held;
    logic [`EMU_DATA_W-1:0] w_data_q;
    logic                   w_err_q;
    logic                   w_held;
    logic                   b_pend;
    axil_resp_e             b_resp_q;
    logic                   wr_fire;

    emu_reg_e               ar_addr_q;
    logic                   ar_held;
    logic                   r_pend;
    logic [`EMU_DATA_W-1:0] r_data_q;
    logic [`EMU_DATA_W-1:0] rd_mux;
    logic                   rd_sample;

    // A pending response holds off new addresses on its own channel
    assign s_awready = !aw_held && !b_pend;
    assign s_wready  = !w_held && !b_pend;
    assign s_arready = !ar_held;

    assign wr_fire   = aw_held && w_held;
    assign rd_sample = ar_held && !r_pend;

    // Holding registers and sampled read data
    always_ff @(posedge clk) begin
        if (s_awvalid && s_awready) begin
            aw_addr_q <= emu_reg_e'(s_awaddr);
        end
        if (s_wvalid && s_wready) begin
            w_data_q <= s_wdata;
            w_err_q  <= (s_wstrb != '1);
        end
        if (wr_fire) begin
            b_resp_q <= w_err_q ? RESP_SLVERR : RESP_OKAY;
        end
        if (s_arvalid && s_arready) begin
            ar_addr_q <= emu_reg_e'(s_araddr);
        end
        if (rd_sample) begin
            r_data_q <= rd_mux;
        end
    end

    // Write channel handshake state
    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            b_pend  <= 1'b0;
        end else begin
            if (s_awvalid && s_awready) begin
                aw_held <= 1'b1;
            end
            if (s_wvalid && s_wready) begin
                w_held <= 1'b1;
            end
            if (wr_fire) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                b_pend  <= 1'b1;
            end
            if (s_bvalid && s_bready) begin
                b_pend <= 1'b0;
            end
        end
    end

    // Read channel, data is taken one cycle after the address lands
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_held <= 1'b0;
            r_pend  <= 1'b0;
        end else begin
            if (s_arvalid && s_arready) begin
                ar_held <= 1'b1;
            end
            if (rd_sample) begin
                r_pend <= 1'b1;
            end
            if (s_rvalid && s_rready) begin
                ar_held <= 1'b0;
                r_pend  <= 1'b0;
            end
        end
    end

    assign s_bvalid = b_pend;
    assign s_bresp  = b_resp_q;
    assign s_rvalid = r_pend;
    assign s_rdata  = r_data_q;
    assign s_rresp  = RESP_OKAY;

    // Both targets see the same access, a partial strobe never reaches them
    assign run_bus.wr_en   = wr_fire && !w_err_q;
    assign run_bus.wr_addr = aw_addr_q;
    assign run_bus.wr_data = w_data_q;
    assign run_bus.rd_addr = ar_addr_q;

    assign dma_bus.wr_en   = wr_fire && !w_err_q;
    assign dma_bus.wr_addr = aw_addr_q;
    assign dma_bus.wr_data = w_data_q;
    assign dma_bus.rd_addr = ar_addr_q;

    // Targets decode their own addresses, unmapped reads return zero
    always_comb begin
        if (run_bus.rd_hit) begin
            rd_mux = run_bus.rd_data;
        end else if (dma_bus.rd_hit) begin
            rd_mux = dma_bus.rd_data;
        end else begin
            rd_mux = '0;
        end
    end

endmodule

/* csr_if.sv */
`timescale 1ns/100ps
`include "emu_config.svh"

interface csr_if import emu_pkg::*; ();

    // Write side, wr_en pulses once per accepted full-strobe write
    logic                   wr_en;
    emu_reg_e               wr_addr;
    logic [`EMU_DATA_W-1:0] wr_data;

    // Read side, rd_data and rd_hit follow rd_addr combinationally
    emu_reg_e               rd_addr;
    logic [`EMU_DATA_W-1:0] rd_data;
    logic                   rd_hit;

    modport host (
        output wr_en,
        output wr_addr,
        output wr_data,
        output rd_addr,
        input  rd_data,
        input  rd_hit
    );

    modport target (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data,
        output rd_hit
    );

endinterface

/* emu_pkg.sv */
`include "emu_config.svh"

package emu_pkg;

    // Register map, byte addresses on the AXI-Lite slave
    typedef enum logic [`EMU_ADDR_W-1:0] {
        REG_STAT        = 12'h000,
        REG_CTRL        = 12'h004,
        REG_CYCLE_LO    = 12'h008,
        REG_CYCLE_HI    = 12'h00C,
        REG_STEP        = 12'h010,
        REG_CKPT_SIZE   = 12'h014,
        REG_DMA_ADDR_LO = 12'h018,
        REG_DMA_ADDR_HI = 12'h01C,
        REG_DMA_STAT    = 12'h020,
        REG_DMA_CTRL    = 12'h024
    } emu_reg_e;

    // AXI-Lite response codes in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // Checkpoint transfer direction
    // SAVE moves DUT state out to memory, LOAD brings it back in
    typedef enum logic {
        DIR_SAVE = 1'b0,
        DIR_LOAD = 1'b1
    } dma_dir_e;

endpackage

/* emu_config.svh */
`ifndef EMU_CONFIG_SVH
`define EMU_CONFIG_SVH

// Register bus widths
`define EMU_ADDR_W 12
`define EMU_DATA_W 32
`define EMU_STRB_W (`EMU_DATA_W / 8)

// Cycle counter and checkpoint address width
`define EMU_WIDE_W 64

// Descriptor and status field widths
`define EMU_DMA_LEN_W 28
`define EMU_DMA_ERR_W 4

// Scan chain sizes in 8-byte words
`define EMU_CHAIN_FF_WORDS 10
`define EMU_CHAIN_MEM_WORDS 22

// Checkpoint size in bytes, both chains together
`define EMU_CKPT_BYTES (8 * (`EMU_CHAIN_FF_WORDS + `EMU_CHAIN_MEM_WORDS))

// STAT bit positions
`define EMU_STAT_HALT_BIT 0
`define EMU_STAT_RESET_BIT 1

// DMA_CTRL and DMA_STAT bit positions
`define EMU_DMA_START_BIT 0
`define EMU_DMA_DIR_BIT 1
`define EMU_DMA_RUN_BIT 0
`define EMU_DMA_ERR_LSB 4

// The DUT comes out of reset halted and held in reset
`define EMU_RST_HALT 1'b1
`define EMU_RST_DUT_RESET 1'b1

`endif
